// ==== Makefile ====
# Verilator build, run, lint and clean for the branch unit

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= branchUnitTb
RTL_TOP    ?= branchUnit
FILELIST   ?= branchUnit.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== branchUnit.f ====
+incdir+verif
source/branchPkg.sv
source/branchDecoder.sv
source/branchComparator.sv
source/branchExecute.sv
source/pcCounter.sv
source/branchSequencer.sv
source/branchUnit.sv
verif/branchUnitTb.sv

// ==== source/branchComparator.sv ====
// Six-way conditional branch evaluation on two operands

`timescale 1ns/1ps

module branchComparator
	#(
		// Operand width
		parameter int dataWidth = 32
	)
	(
		// Selected comparison
		input  branchPkg::branchOpT    op,
		// First source operand
		input  logic [dataWidth-1:0]   operand1,
		// Second source operand
		input  logic [dataWidth-1:0]   operand2,
		// High when the branch condition holds
		output logic                   condition
	);

	// Shared comparison results
	logic isEqual;
	logic signedLess;
	logic unsignedLess;

	// Equality is sign agnostic
	assign isEqual = (operand1 == operand2);

	// Two's complement ordering
	assign signedLess = ($signed(operand1) < $signed(operand2));

	// Plain magnitude ordering
	assign unsignedLess = (operand1 < operand2);

	// --------------------------------------------------
	// Comparison select
	// --------------------------------------------------

	always_comb
	begin
		case (op)
			// Equal
			branchPkg::BEQ:  condition = isEqual;
			// Not equal
			branchPkg::BNE:  condition = !isEqual;
			// Signed less than
			branchPkg::BLT:  condition = signedLess;
			// Signed greater or equal
			branchPkg::BGE:  condition = !signedLess;
			// Unsigned less than
			branchPkg::BLTU: condition = unsignedLess;
			// Unsigned greater or equal
			branchPkg::BGEU: condition = !unsignedLess;
			// Reserved codes never branch
			default:         condition = 1'b0;
		endcase
	end

endmodule

// ==== source/branchDecoder.sv ====
// Combinational decode of an instruction word into the decoded struct

`timescale 1ns/1ps

module branchDecoder
	(
		// Raw instruction word
		input  logic [31:0]                instWord,
		// Decoded fields
		output branchPkg::decodedInstT     decoded
	);

	// Instruction fields
	logic [6:0]  majorOpcode;
	logic [2:0]  funct3;
	logic        opMatch;
	logic        reservedF3;
	logic [12:0] immB;

	// --------------------------------------------------
	// Field extraction
	// --------------------------------------------------

	// Opcode sits in the low seven bits
	assign majorOpcode = instWord[6:0];

	// funct3 selects the comparison
	assign funct3 = instWord[14:12];

	// Branch group detect
	assign opMatch = (majorOpcode == branchPkg::branchOpcode);

	// funct3 values 2 and 3 have no branch meaning
	assign reservedF3 = (funct3 == 3'd2) || (funct3 == 3'd3);

	// B-type immediate
	// bit 12 from 31, bit 11 from 7, bits 10..5 from 30..25, bits 4..1 from 11..8
	assign immB = {instWord[31], instWord[7], instWord[30:25], instWord[11:8], 1'b0};

	// --------------------------------------------------
	// Struct assembly
	// --------------------------------------------------

	always_comb
	begin
		// Only the branch group counts as a branch
		decoded.isBranch = opMatch;

		// Reserved funct3 is illegal only under the branch opcode
		decoded.illegal  = opMatch && reservedF3;

		// Raw funct3 passed through, reserved codes included
		decoded.op       = branchPkg::branchOpT'(funct3);

		// Sign extension of the 13-bit immediate to 32 bits
		decoded.offset   = {{19{immB[12]}}, immB};
	end

endmodule

// ==== source/branchExecute.sv ====
// Execute stage, captures decoded instruction and operands
// then registers the qualified branch outcome one cycle later

`timescale 1ns/1ps

module branchExecute
	#(
		// Operand width
		parameter int dataWidth = 32
	)
	(
		input  logic                       clk,
		input  logic                       arstN,
		// Accept strobe from the sequencer
		input  logic                       capture,
		// Decoder output for the current word
		input  branchPkg::decodedInstT     decoded,
		input  logic [dataWidth-1:0]       operand1,
		input  logic [dataWidth-1:0]       operand2,
		// Held copy of the accepted instruction
		output branchPkg::decodedInstT     stored,
		// Registered branch outcome
		output logic                       taken,
		// Registered reserved funct3 flag
		output logic                       illegal
	);

	// Held operands
	logic [dataWidth-1:0] heldOp1;
	logic [dataWidth-1:0] heldOp2;

	// Marks the EXEC cycle
	logic evalPending;

	// Raw comparator output
	logic condition;

	// Comparison on the held values
	branchComparator #(
		.dataWidth (dataWidth)
	) comparator_i (
		.op        (stored.op),
		.operand1  (heldOp1),
		.operand2  (heldOp2),
		.condition (condition)
	);

	// --------------------------------------------------
	// Capture and evaluate
	// --------------------------------------------------

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			stored      <= '0;
			heldOp1     <= '0;
			heldOp2     <= '0;
			evalPending <= 1'b0;
			taken       <= 1'b0;
			illegal     <= 1'b0;
		end
		else
		begin
			// Follows capture by one cycle
			evalPending <= capture;

			// Instruction and operands latched at the accept edge
			if (capture)
			begin
				stored  <= decoded;
				heldOp1 <= operand1;
				heldOp2 <= operand2;
			end

			// Outcome registered at the end of EXEC, held until the next one
			if (evalPending)
			begin
				taken   <= condition && stored.isBranch && !stored.illegal;
				illegal <= stored.illegal;
			end
		end
	end

endmodule

// ==== source/branchPkg.sv ====
// Shared types and constants for the branch resolution slice
// Branch comparison codes, sequencer states, decoded instruction struct

package branchPkg;

	// --------------------------------------------------
	// Encodings
	// --------------------------------------------------

	// Major opcode of the conditional branch group
	localparam logic [6:0] branchOpcode = 7'b1100011;

	// Sequential advance of the program counter
	localparam logic [31:0] pcStep = 32'd4;

	// --------------------------------------------------
	// Enumerations
	// --------------------------------------------------

	// Branch comparisons, values follow funct3
	// Codes 2 and 3 are reserved and have no member
	typedef enum logic [2:0] {
		BEQ  = 3'd0,
		BNE  = 3'd1,
		BLT  = 3'd4,
		BGE  = 3'd5,
		BLTU = 3'd6,
		BGEU = 3'd7
	} branchOpT;

	// Multicycle sequencer phases
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		EXEC   = 2'd1,
		UPDATE = 2'd2
	} seqStateT;

	// --------------------------------------------------
	// Decoded instruction
	// --------------------------------------------------

	// Fields pulled out of one instruction word
	typedef struct packed {
		// Major opcode matched the branch group
		logic        isBranch;
		// Branch opcode with funct3 of 2 or 3
		logic        illegal;
		// Comparison selected by funct3
		branchOpT    op;
		// Sign-extended B-type immediate, LSB always zero
		logic [31:0] offset;
	} decodedInstT;

endpackage

// ==== source/branchSequencer.sv ====
// Three-state sequencer for the multicycle branch slice
// Drives capture, update and busy

`timescale 1ns/1ps

module branchSequencer
	(
		input  logic clk,
		input  logic arstN,
		// New instruction strobe, ignored while busy
		input  logic instValid,
		// Load strobe for the execute stage
		output logic capture,
		// PC update strobe, also done
		output logic update,
		// High outside IDLE
		output logic busy
	);

	// Current and next phase
	branchPkg::seqStateT state;
	branchPkg::seqStateT nextState;

	// --------------------------------------------------
	// State register
	// --------------------------------------------------

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= branchPkg::IDLE;
		end
		else
		begin
			state <= nextState;
		end
	end

	// --------------------------------------------------
	// Transitions
	// --------------------------------------------------

	always_comb
	begin
		// Hold by default
		nextState = state;
		case (state)
			// Wait for a strobe
			branchPkg::IDLE:
			begin
				if (instValid)
				begin
					nextState = branchPkg::EXEC;
				end
			end
			// Comparator evaluates the held operands
			branchPkg::EXEC:   nextState = branchPkg::UPDATE;
			// PC written at the end of this cycle
			branchPkg::UPDATE: nextState = branchPkg::IDLE;
			// Unused encoding falls back to idle
			default:           nextState = branchPkg::IDLE;
		endcase
	end

	// --------------------------------------------------
	// Outputs
	// --------------------------------------------------

	// Accept only from IDLE, strobes during busy are dropped
	assign capture = (state == branchPkg::IDLE) && instValid;

	// Whole UPDATE cycle
	assign update = (state == branchPkg::UPDATE);

	// Any phase but IDLE
	assign busy = (state != branchPkg::IDLE);

endmodule

// ==== source/branchUnit.sv ====
// Top level of the branch resolution slice
// Decoder, sequencer, execute stage and program counter

`timescale 1ns/1ps

module branchUnit
	#(
		// Operand width
		parameter int          dataWidth = 32,
		// Program counter reset vector
		parameter logic [31:0] resetPc   = 32'h0000_0000
	)
	(
		input  logic                 clk,
		input  logic                 arstN,
		// One-cycle instruction strobe
		input  logic                 instValid,
		// Instruction word, sampled with instValid
		input  logic [31:0]          instWord,
		// Register operands, sampled with instValid
		input  logic [dataWidth-1:0] operand1,
		input  logic [dataWidth-1:0] operand2,
		// Program counter
		output logic [31:0]          pc,
		// Instruction in flight
		output logic                 busy,
		// One-cycle completion pulse
		output logic                 done,
		// Branch outcome, valid with done
		output logic                 taken,
		// Reserved funct3 seen, valid with done
		output logic                 illegal
	);

	// --------------------------------------------------
	// Internal wiring
	// --------------------------------------------------

	// Decoder to execute stage
	branchPkg::decodedInstT decoded;

	// Execute stage to counter
	branchPkg::decodedInstT stored;

	// Sequencer strobes
	logic captureStrobe;
	logic updateStrobe;

	// Completion is the update cycle itself
	assign done = updateStrobe;

	// Word to struct, no state
	branchDecoder decoder_i (
		.instWord (instWord),
		.decoded  (decoded)
	);

	// Phase control
	branchSequencer sequencer_i (
		.clk       (clk),
		.arstN     (arstN),
		.instValid (instValid),
		.capture   (captureStrobe),
		.update    (updateStrobe),
		.busy      (busy)
	);

	// Capture and compare
	branchExecute #(
		.dataWidth (dataWidth)
	) execute_i (
		.clk      (clk),
		.arstN    (arstN),
		.capture  (captureStrobe),
		.decoded  (decoded),
		.operand1 (operand1),
		.operand2 (operand2),
		.stored   (stored),
		.taken    (taken),
		.illegal  (illegal)
	);

	// Program counter
	pcCounter #(
		.resetPc (resetPc)
	) counter_i (
		.clk    (clk),
		.arstN  (arstN),
		.update (updateStrobe),
		.taken  (taken),
		.stored (stored),
		.pc     (pc)
	);

endmodule

// ==== source/pcCounter.sv ====
// Program counter register with reset vector
// Sequential advance or branch target load on update

`timescale 1ns/1ps

module pcCounter
	#(
		// Reset vector
		parameter logic [31:0] resetPc = 32'h0000_0000
	)
	(
		input  logic                       clk,
		input  logic                       arstN,
		// High for the UPDATE cycle
		input  logic                       update,
		// Registered branch outcome
		input  logic                       taken,
		// Held instruction, offset field is used
		input  branchPkg::decodedInstT     stored,
		// Current program counter
		output logic [31:0]                pc
	);

	// Candidate next values
	logic [31:0] seqPc;
	logic [31:0] targetPc;
	logic [31:0] nextPc;

	// --------------------------------------------------
	// Next PC
	// --------------------------------------------------

	// Fall through address
	assign seqPc = pc + branchPkg::pcStep;

	// Branch target, wraps on overflow
	assign targetPc = pc + stored.offset;

	// Taken picks the target
	assign nextPc = taken ? targetPc : seqPc;

	// --------------------------------------------------
	// PC register
	// --------------------------------------------------

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= resetPc;
		end
		else if (update)
		begin
			// One step per instruction
			pc <= nextPc;
		end
	end

endmodule

// ==== verif/branchVectors.svh ====
// Stimulus and expected-value table for the branch unit testbench
// Row type and rows, applied in order by the testbench loop

`ifndef BRANCH_VECTORS_SVH
`define BRANCH_VECTORS_SVH

// Columns: instWord, operand1, operand2, expTaken, expIllegal, randomOps
// randomOps rows get fresh operands and a modelled expTaken
typedef struct packed {
	logic [31:0] instWord;
	logic [31:0] operand1;
	logic [31:0] operand2;
	logic        expTaken;
	logic        expIllegal;
	logic        randomOps;
} vectorT;

localparam int numVectors = 22;

vectorT vectors [numVectors] = '{
	// Each comparison true then false, offset +8
	'{32'h0020_8463, 32'h0000_0005, 32'h0000_0005, 1'b1, 1'b0, 1'b0},
	'{32'h0020_8463, 32'h0000_0005, 32'h0000_0006, 1'b0, 1'b0, 1'b0},
	'{32'h0020_9463, 32'h0000_0005, 32'h0000_0006, 1'b1, 1'b0, 1'b0},
	'{32'hFE20_9CE3, 32'h0000_0007, 32'h0000_0007, 1'b0, 1'b0, 1'b0},
	// Signed and unsigned disagree on all ones against one
	'{32'h0020_C463, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1, 1'b0, 1'b0},
	'{32'h0020_C463, 32'h0000_0001, 32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0},
	'{32'h0020_D463, 32'h0000_0003, 32'h0000_0003, 1'b1, 1'b0, 1'b0},
	'{32'h0020_D463, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 1'b0, 1'b0},
	'{32'h0020_E463, 32'h0000_0001, 32'hFFFF_FFFF, 1'b1, 1'b0, 1'b0},
	'{32'h0020_E463, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 1'b0, 1'b0},
	'{32'h0020_F463, 32'h0000_0009, 32'h0000_0009, 1'b1, 1'b0, 1'b0},
	'{32'h0020_F463, 32'h0000_0001, 32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0},
	// Taken with offset -8, then taken with +16
	'{32'hFE20_9CE3, 32'h0000_0001, 32'h0000_0002, 1'b1, 1'b0, 1'b0},
	'{32'h0020_8863, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 1'b0},
	// ADDI and ADD, never branch
	'{32'h0050_0093, 32'h0000_0004, 32'h0000_0004, 1'b0, 1'b0, 1'b0},
	'{32'h0020_81B3, 32'h0000_0001, 32'h0000_0002, 1'b0, 1'b0, 1'b0},
	// Reserved funct3 2 and 3
	'{32'h0020_A463, 32'h0000_0003, 32'h0000_0003, 1'b0, 1'b1, 1'b0},
	'{32'h0020_B463, 32'h0000_0001, 32'h0000_0002, 1'b0, 1'b1, 1'b0},
	// Random operands: BLT, BGEU, BNE, BEQ
	'{32'h0020_C463, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1},
	'{32'h0020_F463, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1},
	'{32'h0020_9463, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1},
	'{32'h0020_8463, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b1}
};

`endif

// ==== verif/branchUnitTb.sv ====
// Testbench for the branch resolution slice
// Table-driven stimulus, reference model, checks, watchdog and summary

`timescale 1ns/1ps

module branchUnitTb;

	// Reset vector of the DUT with default parameters
	localparam logic [31:0] resetVector = 32'h0000_0000;

	// Reserved branch word with zero offset, driven while the DUT is busy
	localparam logic [31:0] strayWord = 32'h0000_2063;

	`include "branchVectors.svh"

	// DUT signals
	logic        clk = 1'b0;
	logic        arstN;
	logic        instValid;
	logic [31:0] instWord;
	logic [31:0] operand1;
	logic [31:0] operand2;
	logic [31:0] pc;
	logic        busy;
	logic        done;
	logic        taken;
	logic        illegal;

	// Bookkeeping
	int          seed = 71;
	int          passCount = 0;
	int          failCount = 0;
	int          rowErrors;
	logic [31:0] modelPc;

	branchUnit branchUnit_i (
		.clk       (clk),
		.arstN     (arstN),
		.instValid (instValid),
		.instWord  (instWord),
		.operand1  (operand1),
		.operand2  (operand2),
		.pc        (pc),
		.busy      (busy),
		.done      (done),
		.taken     (taken),
		.illegal   (illegal)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// B-type immediate sign-extended from bit 31
	function automatic logic [31:0] branchOffset(input logic [31:0] word);
		return {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
	endfunction

	// Branch condition per funct3
	// Reserved codes and non-branches never taken
	function automatic logic expectTaken(input logic [31:0] word, a, b);
		logic isBranch;
		isBranch = (word[6:0] == branchPkg::branchOpcode);
		case (word[14:12])
			3'd0:    return isBranch && (a == b);
			3'd1:    return isBranch && (a != b);
			3'd4:    return isBranch && ($signed(a) < $signed(b));
			3'd5:    return isBranch && ($signed(a) >= $signed(b));
			3'd6:    return isBranch && (a < b);
			3'd7:    return isBranch && (a >= b);
			default: return 1'b0;
		endcase
	endfunction

	// --------------------------------------------------
	// Checks and reporting
	// --------------------------------------------------

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
			rowErrors++;
		end
	endtask

	// One line per finished test
	task automatic recordResult(input string label);
		if (rowErrors == 0)
		begin
			passCount++;
			$display("%s ok, pc %h", label, pc);
		end
		else
		begin
			failCount++;
			$display("%s failed with %0d errors", label, rowErrors);
		end
	endtask

	// Strobe one row, follow it through EXEC and UPDATE, then check the PC
	task automatic runVector(input int idx);
		vectorT row;
		logic   expTaken;
		int     cycleCount;
		row = vectors[idx];
		if (row.randomOps)
			expTaken = expectTaken(row.instWord, row.operand1, row.operand2);
		else
			expTaken = row.expTaken;
		rowErrors = 0;
		@(posedge clk);
		instValid <= 1'b1;
		instWord  <= row.instWord;
		operand1  <= row.operand1;
		operand2  <= row.operand2;
		// Accept edge
		// Odd rows leave the strobe up into EXEC where it must be ignored
		@(posedge clk);
		instValid <= idx[0];
		// A captured stray word would change illegal and the branch target
		instWord  <= strayWord;
		@(negedge clk);
		checkValue("busy", 32'd1, 32'(busy));
		checkValue("done", 32'd0, 32'(done));
		cycleCount = 1;
		do
		begin
			@(posedge clk);
			instValid <= 1'b0;
			@(negedge clk);
			cycleCount++;
			checkValue("busy", 32'd1, 32'(busy));
		end
		while (!done);
		checkValue("done delay", 32'd2, cycleCount);
		checkValue("taken", 32'(expTaken), 32'(taken));
		checkValue("illegal", 32'(row.expIllegal), 32'(illegal));
		// Model PC follows the expected outcome
		if (expTaken)
			modelPc = modelPc + branchOffset(row.instWord);
		else
			modelPc = modelPc + branchPkg::pcStep;
		@(negedge clk);
		checkValue("pc", modelPc, pc);
		checkValue("busy", 32'd0, 32'(busy));
		checkValue("done", 32'd0, 32'(done));
		// Outcome holds after UPDATE until the next accept
		checkValue("taken", 32'(expTaken), 32'(taken));
		checkValue("illegal", 32'(row.expIllegal), 32'(illegal));
		recordResult($sformatf("row %0d", idx));
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------

	initial
	begin
		arstN     = 1'b0;
		instValid = 1'b0;
		instWord  = '0;
		operand1  = '0;
		operand2  = '0;
		modelPc   = resetVector;
		// Random operands for the marked rows
		for (int i = 0; i < numVectors; i++)
		begin
			if (vectors[i].randomOps)
			begin
				vectors[i].operand1 = $random(seed);
				vectors[i].operand2 = $random(seed);
			end
		end
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		rowErrors = 0;
		checkValue("pc", resetVector, pc);
		checkValue("busy", 32'd0, 32'(busy));
		checkValue("done", 32'd0, 32'(done));
		checkValue("taken", 32'd0, 32'(taken));
		checkValue("illegal", 32'd0, 32'(illegal));
		recordResult("reset");
		for (int i = 0; i < numVectors; i++)
		begin
			runVector(i);
		end
		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog allows about six cycles per row plus reset margin
	initial
	begin
		#((numVectors * 6 + 20) * 40);
		$display("timeout: done never arrived, the DUT stopped responding");
		$display("TEST FAILED");
		$finish;
	end

endmodule
